//--- common/mpx_decode_pkg.sv
// MPX decode shared types

`default_nettype none

package mpx_decode_pkg;

    `include "mpx_decode_settings.svh"

    // --------------------
    // Field types
    // --------------------
    typedef logic [`MPX_XLEN-1:0] instr_t;
    typedef logic [`MPX_XLEN-1:0] pc_t;
    typedef logic [5:0]           opcode_t;
    typedef logic [5:0]           funct_t;
    typedef logic [4:0]           reg_sel_t;

    // --------------------
    // Major opcodes
    // --------------------
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_BRCOND  = 6'h01;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_COP0    = 6'h10;
    localparam opcode_t OP_COP1    = 6'h11;
    localparam opcode_t OP_LB      = 6'h20;
    localparam opcode_t OP_LH      = 6'h21;
    localparam opcode_t OP_LWL     = 6'h22;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_LBU     = 6'h24;
    localparam opcode_t OP_LHU     = 6'h25;
    localparam opcode_t OP_LWR     = 6'h26;
    localparam opcode_t OP_SB      = 6'h28;
    localparam opcode_t OP_SH      = 6'h29;
    localparam opcode_t OP_SWL     = 6'h2a;
    localparam opcode_t OP_SW      = 6'h2b;
    localparam opcode_t OP_SWR     = 6'h2e;
    localparam opcode_t OP_LWC0    = 6'h30;
    localparam opcode_t OP_LWC1    = 6'h31;
    localparam opcode_t OP_SWC0    = 6'h38;
    localparam opcode_t OP_SWC1    = 6'h39;

    // --------------------
    // SPECIAL functions
    // --------------------
    localparam funct_t FN_SLL     = 6'h00;
    localparam funct_t FN_SRL     = 6'h02;
    localparam funct_t FN_SRA     = 6'h03;
    localparam funct_t FN_SLLV    = 6'h04;
    localparam funct_t FN_SRLV    = 6'h06;
    localparam funct_t FN_SRAV    = 6'h07;
    localparam funct_t FN_JALR    = 6'h09;
    localparam funct_t FN_SYSCALL = 6'h0c;
    localparam funct_t FN_BREAK   = 6'h0d;
    localparam funct_t FN_MFHI    = 6'h10;
    localparam funct_t FN_MTHI    = 6'h11;
    localparam funct_t FN_MFLO    = 6'h12;
    localparam funct_t FN_MTLO    = 6'h13;
    localparam funct_t FN_MULT    = 6'h18;
    localparam funct_t FN_MULTU   = 6'h19;
    localparam funct_t FN_DIV     = 6'h1a;
    localparam funct_t FN_DIVU    = 6'h1b;
    localparam funct_t FN_ADD     = 6'h20;
    localparam funct_t FN_ADDU    = 6'h21;
    localparam funct_t FN_SUB     = 6'h22;
    localparam funct_t FN_SUBU    = 6'h23;
    localparam funct_t FN_AND     = 6'h24;
    localparam funct_t FN_OR      = 6'h25;
    localparam funct_t FN_XOR     = 6'h26;
    localparam funct_t FN_NOR     = 6'h27;
    localparam funct_t FN_SLT     = 6'h2a;
    localparam funct_t FN_SLTU    = 6'h2b;

    // Coprocessor move forms in the rs field
    localparam reg_sel_t RS_MF = 5'b00000;
    localparam reg_sel_t RS_CF = 5'b00010;
    localparam reg_sel_t RS_MT = 5'b00100;
    localparam reg_sel_t RS_CT = 5'b00110;

    localparam funct_t FN_RFE = 6'b010000;

    // BLTZAL/BGEZAL write the link register
    localparam reg_sel_t BRCOND_LINK_MASK = 5'b11110;
    localparam reg_sel_t BRCOND_LINK_VAL  = 5'b10000;

    // --------------------
    // Pipeline payloads
    // --------------------
    typedef struct packed {
        instr_t instr;
        pc_t    pc;
        logic   delay_slot;
        logic   fault;
    } fetch_entry_t;

    typedef struct packed {
        fetch_entry_t fetch;
        logic         rd_valid;
        logic         rt_is_rd;
        logic         lr_is_rd;
        logic         lsu;
        logic         mul;
        logic         div;
        logic         cop0;
        logic         cop0_wr;
        logic         cop1;
        logic         cop1_wr;
    } decoded_entry_t;

endpackage

`default_nettype wire

//--- common/mpx_decode_settings.svh
// MPX decode configuration

`ifndef MPX_DECODE_SETTINGS_SVH
`define MPX_DECODE_SETTINGS_SVH

// --------------------
// Multiply and divide
// --------------------

// Set to 1 to decode MULT/DIV and the HI/LO moves
`define MPX_SUPPORT_MULDIV 1'b1

// --------------------
// Coprocessors
// --------------------

// Enable mask with bit 0 for COP0 and bit 1 for COP1
`define MPX_SUPPORTED_COP 2'b11

// --------------------
// Word sizes
// --------------------

// Instruction and PC width
`define MPX_XLEN 32

`endif

//--- decode/mpx_cop_class.sv
// Coprocessor decode

`timescale 1ns/10ps
`default_nettype none

`include "mpx_decode_settings.svh"

module mpx_cop_class (
    input  wire mpx_decode_pkg::instr_t instr_i,
    input  wire                         fault_i,
    output logic                        cop_rd_o,
    output logic                        cop0_o,
    output logic                        cop0_wr_o,
    output logic                        cop1_o,
    output logic                        cop1_wr_o
);

    import mpx_decode_pkg::*;

    localparam bit         MULDIV_EN = `MPX_SUPPORT_MULDIV;
    localparam logic [1:0] COP_EN    = `MPX_SUPPORTED_COP;

    opcode_t  opcode_w;
    reg_sel_t rs_w;
    funct_t   funct_w;
    logic     special_w;

    assign opcode_w  = instr_i[31:26];
    assign rs_w      = instr_i[25:21];
    assign funct_w   = instr_i[5:0];
    assign special_w = (opcode_w == OP_SPECIAL);

    // HI/LO moves go through COP0
    logic mfhi_w, mflo_w, mthi_w, mtlo_w;
    assign mfhi_w = MULDIV_EN && special_w && (funct_w == FN_MFHI);
    assign mflo_w = MULDIV_EN && special_w && (funct_w == FN_MFLO);
    assign mthi_w = MULDIV_EN && special_w && (funct_w == FN_MTHI);
    assign mtlo_w = MULDIV_EN && special_w && (funct_w == FN_MTLO);

    // --------------------
    // COP0
    // --------------------
    logic cop0_op_w, cop0_co_w, mfc0_w, cfc0_w, mtc0_w, ctc0_w, rfe_w, lwc0_w;
    assign cop0_op_w = (opcode_w == OP_COP0) && COP_EN[0];
    assign cop0_co_w = cop0_op_w && instr_i[25];
    assign mfc0_w    = cop0_op_w && (rs_w == RS_MF);
    assign cfc0_w    = cop0_op_w && (rs_w == RS_CF);
    assign mtc0_w    = cop0_op_w && (rs_w == RS_MT);
    assign ctc0_w    = cop0_op_w && (rs_w == RS_CT);
    assign rfe_w     = cop0_co_w && (funct_w == FN_RFE);
    assign lwc0_w    = (opcode_w == OP_LWC0) && COP_EN[0];

    // --------------------
    // COP1
    // --------------------
    logic cop1_op_w, cop1_co_w, mfc1_w, cfc1_w, mtc1_w, ctc1_w, lwc1_w, swc1_w;
    assign cop1_op_w = (opcode_w == OP_COP1) && COP_EN[1];
    assign cop1_co_w = cop1_op_w && instr_i[25];
    assign mfc1_w    = cop1_op_w && (rs_w == RS_MF);
    assign cfc1_w    = cop1_op_w && (rs_w == RS_CF);
    assign mtc1_w    = cop1_op_w && (rs_w == RS_MT);
    assign ctc1_w    = cop1_op_w && (rs_w == RS_CT);
    assign lwc1_w    = (opcode_w == OP_LWC1) && COP_EN[1];
    assign swc1_w    = (opcode_w == OP_SWC1) && COP_EN[1];

    assign cop_rd_o = mfhi_w | mflo_w | mfc0_w | mfc1_w;

    // A fetch fault or an unsupported COP0 opcode still goes to COP0
    assign cop0_o = (special_w && (funct_w == FN_SYSCALL || funct_w == FN_BREAK)) |
                    (opcode_w == OP_COP0) | mfc0_w | cfc0_w | mtc0_w | ctc0_w | rfe_w |
                    mfhi_w | mflo_w | mthi_w | mtlo_w | fault_i;

    assign cop0_wr_o = mtc0_w | ctc0_w | lwc0_w | mthi_w | mtlo_w | rfe_w;

    assign cop1_o = cop1_op_w | cop1_co_w | mfc1_w | cfc1_w | mtc1_w | ctc1_w |
                    lwc1_w | swc1_w;

    assign cop1_wr_o = mtc1_w | ctc1_w | lwc1_w;

endmodule

`default_nettype wire

//--- decode/mpx_op_class.sv
// Writeback, memory and muldiv classifier

`timescale 1ns/10ps
`default_nettype none

`include "mpx_decode_settings.svh"

module mpx_op_class (
    input  wire mpx_decode_pkg::instr_t instr_i,
    input  wire                         cop_rd_i,
    output logic                        rd_valid_o,
    output logic                        rt_is_rd_o,
    output logic                        lr_is_rd_o,
    output logic                        lsu_o,
    output logic                        mul_o,
    output logic                        div_o
);

    import mpx_decode_pkg::*;

    localparam bit         MULDIV_EN = `MPX_SUPPORT_MULDIV;
    localparam logic [1:0] COP_EN    = `MPX_SUPPORTED_COP;

    opcode_t  opcode_w;
    funct_t   funct_w;
    reg_sel_t rt_w;
    logic     special_w;
    logic     imm_alu_w;
    logic     load_w;
    logic     store_w;
    logic     alu_r_w;
    logic     link_w;

    assign opcode_w  = instr_i[31:26];
    assign rt_w      = instr_i[20:16];
    assign funct_w   = instr_i[5:0];
    assign special_w = (opcode_w == OP_SPECIAL);

    // --------------------
    // Major opcode groups
    // --------------------
    always_comb begin
        imm_alu_w = 1'b0;
        load_w    = 1'b0;
        store_w   = 1'b0;
        case (opcode_w)
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
                imm_alu_w = 1'b1;
            OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR:
                load_w = 1'b1;
            OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR:
                store_w = 1'b1;
            default: ;
        endcase
    end

    // Shifts and ALU R-types
    always_comb begin
        alu_r_w = 1'b0;
        if (special_w) begin
            case (funct_w)
                FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
                FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
                    alu_r_w = 1'b1;
                default: ;
            endcase
        end
    end

    assign link_w = (opcode_w == OP_BRCOND) &&
                    ((rt_w & BRCOND_LINK_MASK) == BRCOND_LINK_VAL);

    // --------------------
    // Flags
    // --------------------
    assign rd_valid_o = imm_alu_w | alu_r_w | load_w | link_w | cop_rd_i |
                        (opcode_w == OP_JAL) |
                        (special_w && funct_w == FN_JALR);

    assign rt_is_rd_o = imm_alu_w | load_w |
                        (opcode_w == OP_COP0) | (opcode_w == OP_COP1);

    assign lr_is_rd_o = (opcode_w == OP_JAL) | link_w;

    assign lsu_o = load_w | store_w |
                   ((opcode_w == OP_LWC0 || opcode_w == OP_SWC0) && COP_EN[0]) |
                   ((opcode_w == OP_LWC1 || opcode_w == OP_SWC1) && COP_EN[1]);

    assign mul_o = MULDIV_EN && special_w &&
                   (funct_w == FN_MULT || funct_w == FN_MULTU);

    assign div_o = MULDIV_EN && special_w &&
                   (funct_w == FN_DIV || funct_w == FN_DIVU);

endmodule

`default_nettype wire

//--- hw/mpx_decode_top.sv
// MPX pipelined decode stage

`timescale 1ns/10ps
`default_nettype none

module mpx_decode_top (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         fetch_in_valid_i,
    input  wire mpx_decode_pkg::instr_t fetch_in_instr_i,
    input  wire mpx_decode_pkg::pc_t    fetch_in_pc_i,
    input  wire                         fetch_in_delay_slot_i,
    input  wire                         fetch_in_fault_fetch_i,
    input  wire                         fetch_out_accept_i,
    output logic                        fetch_in_accept_o,
    output logic                        fetch_out_valid_o,
    output mpx_decode_pkg::instr_t      fetch_out_instr_o,
    output mpx_decode_pkg::pc_t         fetch_out_pc_o,
    output logic                        fetch_out_delay_slot_o,
    output logic                        fetch_out_fault_fetch_o,
    output logic                        fetch_out_instr_rd_valid_o,
    output logic                        fetch_out_instr_rt_is_rd_o,
    output logic                        fetch_out_instr_lr_is_rd_o,
    output logic                        fetch_out_instr_lsu_o,
    output logic                        fetch_out_instr_mul_o,
    output logic                        fetch_out_instr_div_o,
    output logic                        fetch_out_instr_cop0_o,
    output logic                        fetch_out_instr_cop0_wr_o,
    output logic                        fetch_out_instr_cop1_o,
    output logic                        fetch_out_instr_cop1_wr_o
);

    import mpx_decode_pkg::*;

    fetch_entry_t   fetch_in_w;
    fetch_entry_t   fetch_q_w;
    decoded_entry_t dec_w;
    decoded_entry_t dec_q_w;
    logic           slice0_valid_w;
    logic           slice1_accept_w;
    logic           cop_rd_w;

    assign fetch_in_w.instr      = fetch_in_instr_i;
    assign fetch_in_w.pc         = fetch_in_pc_i;
    assign fetch_in_w.delay_slot = fetch_in_delay_slot_i;
    assign fetch_in_w.fault      = fetch_in_fault_fetch_i;

    // --------------------
    // Input slice
    // --------------------
    mpx_pipe_slice #(.payload_t(fetch_entry_t)) u_in_slice (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .in_valid_i   (fetch_in_valid_i),
        .in_data_i    (fetch_in_w),
        .in_accept_o  (fetch_in_accept_o),
        .out_valid_o  (slice0_valid_w),
        .out_data_o   (fetch_q_w),
        .out_accept_i (slice1_accept_w)
    );

    // --------------------
    // Classification
    // --------------------
    mpx_cop_class u_cop_class (
        .instr_i   (fetch_q_w.instr),
        .fault_i   (fetch_q_w.fault),
        .cop_rd_o  (cop_rd_w),
        .cop0_o    (dec_w.cop0),
        .cop0_wr_o (dec_w.cop0_wr),
        .cop1_o    (dec_w.cop1),
        .cop1_wr_o (dec_w.cop1_wr)
    );

    mpx_op_class u_op_class (
        .instr_i    (fetch_q_w.instr),
        .cop_rd_i   (cop_rd_w),
        .rd_valid_o (dec_w.rd_valid),
        .rt_is_rd_o (dec_w.rt_is_rd),
        .lr_is_rd_o (dec_w.lr_is_rd),
        .lsu_o      (dec_w.lsu),
        .mul_o      (dec_w.mul),
        .div_o      (dec_w.div)
    );

    assign dec_w.fetch = fetch_q_w;

    // --------------------
    // Output slice
    // --------------------
    mpx_pipe_slice #(.payload_t(decoded_entry_t)) u_out_slice (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .in_valid_i   (slice0_valid_w),
        .in_data_i    (dec_w),
        .in_accept_o  (slice1_accept_w),
        .out_valid_o  (fetch_out_valid_o),
        .out_data_o   (dec_q_w),
        .out_accept_i (fetch_out_accept_i)
    );

    assign fetch_out_instr_o          = dec_q_w.fetch.instr;
    assign fetch_out_pc_o             = dec_q_w.fetch.pc;
    assign fetch_out_delay_slot_o     = dec_q_w.fetch.delay_slot;
    assign fetch_out_fault_fetch_o    = dec_q_w.fetch.fault;
    assign fetch_out_instr_rd_valid_o = dec_q_w.rd_valid;
    assign fetch_out_instr_rt_is_rd_o = dec_q_w.rt_is_rd;
    assign fetch_out_instr_lr_is_rd_o = dec_q_w.lr_is_rd;
    assign fetch_out_instr_lsu_o      = dec_q_w.lsu;
    assign fetch_out_instr_mul_o      = dec_q_w.mul;
    assign fetch_out_instr_div_o      = dec_q_w.div;
    assign fetch_out_instr_cop0_o     = dec_q_w.cop0;
    assign fetch_out_instr_cop0_wr_o  = dec_q_w.cop0_wr;
    assign fetch_out_instr_cop1_o     = dec_q_w.cop1;
    assign fetch_out_instr_cop1_wr_o  = dec_q_w.cop1_wr;

endmodule

`default_nettype wire

//--- hw/mpx_pipe_slice.sv
// Valid/accept register slice

`timescale 1ns/10ps
`default_nettype none

module mpx_pipe_slice #(
    parameter type payload_t = logic
) (
    input  wire           clk_i,
    input  wire           rst_i,
    input  wire           in_valid_i,
    input  wire payload_t in_data_i,
    output logic          in_accept_o,
    output logic          out_valid_o,
    output payload_t      out_data_o,
    input  wire           out_accept_i
);

    logic     full_q;
    payload_t data_q;
    logic     in_xfer_w;
    logic     out_xfer_w;

    // Take a new entry when empty or when the held one leaves this cycle
    assign in_accept_o = ~full_q | out_accept_i;
    assign in_xfer_w   = in_valid_i & in_accept_o;
    assign out_xfer_w  = full_q & out_accept_i;

    // --------------------
    // Occupancy
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full_q <= 1'b0;
        end else if (in_xfer_w) begin
            full_q <= 1'b1;
        end else if (out_xfer_w) begin
            full_q <= 1'b0;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (in_xfer_w) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

endmodule

`default_nettype wire

//--- list.f
+incdir+common
+incdir+testbench
common/mpx_decode_pkg.sv
hw/mpx_pipe_slice.sv
decode/mpx_op_class.sv
decode/mpx_cop_class.sv
hw/mpx_decode_top.sv
testbench/tb_mpx_decode.sv

//--- testbench/tb_mpx_decode_vectors.svh
// Decode test vectors

`ifndef TB_MPX_DECODE_VECTORS_SVH
`define TB_MPX_DECODE_VECTORS_SVH

// Each row holds the instruction word, the fetch fault and the expected flags
// Flag order rd_valid rt_is_rd lr_is_rd | lsu mul div | cop0 cop0_wr cop1 cop1_wr
task automatic load_vectors();
    // --------------------
    // Writeback class
    // --------------------
    // ADDIU, LW, ADDU, JAL, BGEZAL, JALR, LUI
    add_vector(32'h2422_0005, 1'b0, 10'b110_000_0000);
    add_vector(32'h8c23_0008, 1'b0, 10'b110_100_0000);
    add_vector(32'h0022_2021, 1'b0, 10'b100_000_0000);
    add_vector(32'h0c00_0040, 1'b0, 10'b101_000_0000);
    add_vector(32'h0431_0004, 1'b0, 10'b101_000_0000);
    add_vector(32'h0020_f809, 1'b0, 10'b100_000_0000);
    add_vector(32'h3c07_1234, 1'b0, 10'b110_000_0000);
    // BEQ and BLTZ write nothing
    add_vector(32'h1022_0008, 1'b0, 10'b000_000_0000);
    add_vector(32'h0420_0008, 1'b0, 10'b000_000_0000);
    // --------------------
    // Load/store
    // --------------------
    // SW, SB, LWC1, SWC0, LWC0
    add_vector(32'hac23_0004, 1'b0, 10'b000_100_0000);
    add_vector(32'ha022_0000, 1'b0, 10'b000_100_0000);
    add_vector(32'hc422_0000, 1'b0, 10'b000_100_0011);
    add_vector(32'he022_0000, 1'b0, 10'b000_100_0000);
    add_vector(32'hc022_0000, 1'b0, 10'b000_100_0100);
    // MULT, DIVU, MFHI, MFLO, MTLO, MTHI
    add_vector(32'h0022_0018, 1'b0, 10'b000_010_0000);
    add_vector(32'h0022_001b, 1'b0, 10'b000_001_0000);
    add_vector(32'h0000_2810, 1'b0, 10'b100_000_1000);
    add_vector(32'h0000_3012, 1'b0, 10'b100_000_1000);
    add_vector(32'h0020_0013, 1'b0, 10'b000_000_1100);
    add_vector(32'h0020_0011, 1'b0, 10'b000_000_1100);
    // --------------------
    // Coprocessors
    // --------------------
    // MFC0, MTC1, CTC1, MFC1, RFE, SYSCALL, BREAK
    add_vector(32'h4002_6000, 1'b0, 10'b110_000_1000);
    add_vector(32'h4482_1800, 1'b0, 10'b010_000_0011);
    add_vector(32'h44c2_1800, 1'b0, 10'b010_000_0011);
    add_vector(32'h4402_1800, 1'b0, 10'b110_000_0010);
    add_vector(32'h4200_0010, 1'b0, 10'b010_000_1100);
    add_vector(32'h0000_000c, 1'b0, 10'b000_000_1000);
    add_vector(32'h0000_000d, 1'b0, 10'b000_000_1000);
    // Fetch faults on ADDIU, SW and a NOP
    add_vector(32'h2422_0005, 1'b1, 10'b110_000_1000);
    add_vector(32'hac23_0004, 1'b1, 10'b000_100_1000);
    add_vector(32'h0000_0000, 1'b1, 10'b100_000_1000);
endtask

`endif

//--- testbench/tb_mpx_decode.sv
// MPX decode stage testbench

`timescale 1ns/10ps
`default_nettype none

module tb_mpx_decode;

    localparam int          MAX_VECTORS = 64;
    localparam int          WAIT_LIMIT  = 200;
    localparam logic [31:0] PC_BASE     = 32'hbfc0_0000;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic        in_delay_slot;
    logic        in_fault;
    logic        out_accept;
    wire         in_accept;
    wire         out_valid;
    wire  [31:0] out_instr;
    wire  [31:0] out_pc;
    wire         out_delay_slot;
    wire         out_fault;
    wire  [9:0]  out_flags;

    logic [31:0] vec_instr [0:MAX_VECTORS-1];
    logic        vec_fault [0:MAX_VECTORS-1];
    logic [9:0]  vec_flags [0:MAX_VECTORS-1];
    int          in_cycle  [0:MAX_VECTORS-1];
    int          num_vectors;
    int          cycle_cnt;
    int          error_count;
    int          check_count;
    int          test_count;
    int          seed;
    bit          timed_out;
    bit          collect_done;

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    mpx_decode_top UUT (
        .clk_i                      (clk),
        .rst_i                      (rst),
        .fetch_in_valid_i           (in_valid),
        .fetch_in_instr_i           (in_instr),
        .fetch_in_pc_i              (in_pc),
        .fetch_in_delay_slot_i      (in_delay_slot),
        .fetch_in_fault_fetch_i     (in_fault),
        .fetch_out_accept_i         (out_accept),
        .fetch_in_accept_o          (in_accept),
        .fetch_out_valid_o          (out_valid),
        .fetch_out_instr_o          (out_instr),
        .fetch_out_pc_o             (out_pc),
        .fetch_out_delay_slot_o     (out_delay_slot),
        .fetch_out_fault_fetch_o    (out_fault),
        .fetch_out_instr_rd_valid_o (out_flags[9]),
        .fetch_out_instr_rt_is_rd_o (out_flags[8]),
        .fetch_out_instr_lr_is_rd_o (out_flags[7]),
        .fetch_out_instr_lsu_o      (out_flags[6]),
        .fetch_out_instr_mul_o      (out_flags[5]),
        .fetch_out_instr_div_o      (out_flags[4]),
        .fetch_out_instr_cop0_o     (out_flags[3]),
        .fetch_out_instr_cop0_wr_o  (out_flags[2]),
        .fetch_out_instr_cop1_o     (out_flags[1]),
        .fetch_out_instr_cop1_wr_o  (out_flags[0])
    );

    task automatic add_vector(input logic [31:0] instr, input logic fault,
                              input logic [9:0] flags);
        vec_instr[num_vectors] = instr;
        vec_fault[num_vectors] = fault;
        vec_flags[num_vectors] = flags;
        num_vectors++;
    endtask

    `include "tb_mpx_decode_vectors.svh"

    // --------------------
    // Driver
    // --------------------
    task automatic drive_rows();
        int idx;
        int wait_cnt;
        for (idx = 0; idx < num_vectors && !timed_out; idx++) begin
            in_valid      <= 1'b1;
            in_instr      <= vec_instr[idx];
            in_pc         <= PC_BASE + idx * 4;
            in_delay_slot <= idx[0];
            in_fault      <= vec_fault[idx];
            wait_cnt = 0;
            do begin
                @(posedge clk);
                wait_cnt++;
            end while (!in_accept && wait_cnt < WAIT_LIMIT);
            if (in_accept) begin
                in_cycle[idx] = cycle_cnt;
            end else begin
                $display("Timeout: row %0d was not accepted within %0d cycles", idx, WAIT_LIMIT);
                error_count++;
                timed_out = 1'b1;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_row(input int idx, input bit check_latency);
        logic [31:0] exp_pc;
        exp_pc = PC_BASE + idx * 4;
        check_count += 4;
        assert (out_instr == vec_instr[idx]) else begin
            error_count++;
            $display("FAILED %0t: row %0d instr %h, expected %h",
                     $time, idx, out_instr, vec_instr[idx]);
        end
        assert (out_pc == exp_pc && out_delay_slot == idx[0]) else begin
            error_count++;
            $display("FAILED %0t: row %0d pc %h ds %b, expected %h ds %b",
                     $time, idx, out_pc, out_delay_slot, exp_pc, idx[0]);
        end
        assert (out_fault == vec_fault[idx]) else begin
            error_count++;
            $display("FAILED %0t: row %0d fault %b, expected %b",
                     $time, idx, out_fault, vec_fault[idx]);
        end
        assert (out_flags == vec_flags[idx]) else begin
            error_count++;
            $display("FAILED %0t: row %0d flags %b, expected %b",
                     $time, idx, out_flags, vec_flags[idx]);
        end
        // Output transfer two edges after the input transfer
        if (check_latency) begin
            check_count++;
            assert (cycle_cnt - in_cycle[idx] == 2) else begin
                error_count++;
                $display("FAILED %0t: row %0d latency %0d cycles, expected 2",
                         $time, idx, cycle_cnt - in_cycle[idx]);
            end
        end
    endtask

    // --------------------
    // Checker
    // --------------------
    task automatic collect_rows(input bit check_latency);
        int out_idx;
        int idle_cnt;
        out_idx  = 0;
        idle_cnt = 0;
        while (out_idx < num_vectors && !timed_out) begin
            @(posedge clk);
            if (out_valid && out_accept) begin
                check_row(out_idx, check_latency);
                out_idx++;
                idle_cnt = 0;
            end else if (idle_cnt < WAIT_LIMIT) begin
                idle_cnt++;
            end else begin
                $display("Timeout: no output for %0d cycles, %0d of %0d rows received",
                         WAIT_LIMIT, out_idx, num_vectors);
                error_count++;
                timed_out = 1'b1;
            end
        end
        collect_done = 1'b1;
    endtask

    task automatic drive_backpressure();
        int cycles;
        cycles = 0;
        while (!collect_done && cycles < WAIT_LIMIT * MAX_VECTORS) begin
            @(posedge clk);
            out_accept <= ($random(seed) & 1) != 0;
            cycles++;
        end
        if (!collect_done) begin
            $display("Timeout: checker still running after %0d back-pressure cycles",
                     cycles);
            error_count++;
            timed_out = 1'b1;
        end
        out_accept <= 1'b1;
    endtask

    task automatic run_test(input string name, input bit random_accept);
        int errors_before;
        errors_before = error_count;
        collect_done  = 1'b0;
        fork
            drive_rows();
            collect_rows(!random_accept);
            if (random_accept) drive_backpressure();
        join
        repeat (3) @(posedge clk);
        check_count++;
        assert (!out_valid && in_accept) else begin
            error_count++;
            $display("FAILED %0t: pipeline not empty after the last row", $time);
        end
        test_count++;
        $display("Test %0d (%s): %0d rows, %0d errors",
                 test_count, name, num_vectors, error_count - errors_before);
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_instr      = '0;
        in_pc         = '0;
        in_delay_slot = 1'b0;
        in_fault      = 1'b0;
        out_accept    = 1'b1;
        cycle_cnt     = 0;
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        num_vectors   = 0;
        seed          = 32'h364f_722c;
        timed_out     = 1'b0;
        collect_done  = 1'b0;
        load_vectors();
        repeat (5) @(posedge clk);
        check_count++;
        assert (!out_valid && in_accept) else begin
            error_count++;
            $display("FAILED %0t: wrong handshake state during reset", $time);
        end
        rst <= 1'b0;
        run_test("accept held high", 1'b0);
        if (!timed_out) begin
            run_test("random back-pressure", 1'b1);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
